// ==== sim.f ====
+incdir+logic
logic/glip_fx3_pkg.sv
logic/sync_fifo.sv
logic/slave_fifo_fsm.sv
logic/glip_fx3_top.sv
tests/glip_fx3_properties.sv
tests/fx3_host_model.sv
tests/glip_fx3_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module glip_fx3_tb -o glip_fx3_sim
out=$(./obj_dir/glip_fx3_sim)
echo "$out"
if echo "$out" | grep -qF '*** TEST PASSED ***'; then
   exit 0
else
   exit 1
fi

// ==== tests/glip_fx3_tb.sv ====
// Testbench top for the FX3 bridge; runs ingress, egress, fallback and flush tests
`timescale 1ns/100ps
`include "glip_fx3_macros.svh"

module glip_fx3_tb import glip_fx3_pkg::*; ();

   localparam int n_in = 400;
   localparam int n_eg = 300;
   localparam int cycle_limit = 25 * (n_in + n_eg) + 2500;

   logic fx3_pclk = 1'b0;
   logic rst, fx3_com_rst, com_rst, fx3_dq_oe;
   logic fx3_sloe_n, fx3_slrd_n, fx3_slwr_n, fx3_pktend_n;
   logic fx3_flaga_n, fx3_flagb_n, fx3_flagc_n, fx3_flagd_n;
   logic [1:0] fx3_a;
   fx3_word_t fx3_dq_in, fx3_dq_out, fifo_out_data, fifo_in_data;
   logic fifo_out_valid, fifo_out_ready, fifo_in_valid, fifo_in_ready;
   fx3_word_t in_words[n_in];
   fx3_word_t eg_words[n_eg];
   logic [31:0] data_lfsr, ready_lfsr;
   int err_cnt = 0, cycles = 0, rx_cnt = 0, eg_sent = 0, eg_rx = 0, ready_run = 0, pkt_before;
   logic bp_mode = 1'b0, eg_go = 1'b0, accepted;

   glip_fx3_top #(.buffer_depth(16), .flush_timeout(64)) dut_i (.*);

   fx3_host_model host_i (.fx3_pclk, .rst, .fx3_slrd_n, .fx3_slwr_n, .fx3_pktend_n, .fx3_a,
      .fx3_dq_out, .fx3_dq_in, .fx3_flaga_n, .fx3_flagb_n, .fx3_flagc_n, .fx3_flagd_n);

   bind glip_fx3_top glip_fx3_properties props_i (.fx3_pclk, .int_rst, .fx3_slrd_n,
      .fx3_slwr_n, .fx3_pktend_n, .fx3_a);

   always #4 fx3_pclk = ~fx3_pclk;

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Word n of the combined stream with ingress first and egress after it
   function automatic fx3_word_t expected_word(input int n);
      logic [31:0] s;
      fx3_word_t w;
      s = 32;
      w = '0;
      for (int i = 0; i < `GLIP_FX3_WIDTH * (n + 1); i++) begin
         s = lfsr_next(s);
         w = {w[`GLIP_FX3_WIDTH-2:0], s[0]};
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // Outputs while the bridge is held in reset
   task automatic compare_reset_outputs();
      check_value("com_rst", 1, com_rst);
      check_value("fx3_slrd_n", 1, fx3_slrd_n);
      check_value("fx3_slwr_n", 1, fx3_slwr_n);
      check_value("fx3_sloe_n", 1, fx3_sloe_n);
      check_value("fx3_pktend_n", 1, fx3_pktend_n);
      check_value("fx3_dq_oe", 0, fx3_dq_oe);
      check_value("fifo_in_valid", 0, fifo_in_valid);
      check_value("fifo_out_ready", 1, fifo_out_ready);
   endtask

   always @(posedge fx3_pclk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // Compare words leaving the ingress FIFO
   always @(posedge fx3_pclk) begin
      if (fifo_in_valid && fifo_in_ready) begin
         check_value("fifo_in_data", expected_word(rx_cnt), fifo_in_data);
         rx_cnt++;
      end
   end

   // Bus direction and output enable against the strobes
   always @(posedge fx3_pclk) begin
      if (!com_rst) begin
         if (!fx3_slrd_n) check_value("fx3_sloe_n", 0, fx3_sloe_n);
         if (!fx3_slwr_n || !fx3_pktend_n) check_value("fx3_dq_oe", 1, fx3_dq_oe);
         if (!fx3_sloe_n) check_value("fx3_dq_oe", 0, fx3_dq_oe);
      end
   end

   // Drive ready, feed egress and drain the host's stored words
   always @(posedge fx3_pclk) begin
      accepted = fifo_out_valid && fifo_out_ready;
      #1;
      if (bp_mode && ready_run == 0) begin
         ready_lfsr = lfsr_next(ready_lfsr);
         fifo_in_ready = ready_lfsr[0];
         repeat (6) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            ready_run = ready_run * 2 + int'(ready_lfsr[0]);
         end
         ready_run = ready_run + 1;
      end else if (!bp_mode) begin
         fifo_in_ready = 1'b1;
      end
      if (ready_run > 0) ready_run--;
      if (accepted) eg_sent++;
      fifo_out_valid = eg_go && eg_sent < n_eg;
      fifo_out_data = (eg_sent < n_eg) ? eg_words[eg_sent] : '0;
      // Hold the host between almost full and full during the fallback test
      while (host_i.d2h_q.size() > ((eg_rx >= 200 && eg_sent < n_eg) ? 29 : 0)) begin
         check_value("fx3_dq_out", expected_word(n_in + eg_rx), host_i.d2h_q.pop_front());
         eg_rx++;
      end
   end

   initial begin
      rst = 1'b1;
      fx3_com_rst = 1'b0;
      fifo_out_valid = 1'b0;
      fifo_out_data = '0;
      fifo_in_ready = 1'b1;
      ready_lfsr = 32;
      data_lfsr = 32;
      for (int i = 0; i < n_in + n_eg; i++) begin
         repeat (`GLIP_FX3_WIDTH) data_lfsr = lfsr_next(data_lfsr);
         if (i < n_in) in_words[i] = data_lfsr[`GLIP_FX3_WIDTH-1:0];
         else eg_words[i-n_in] = data_lfsr[`GLIP_FX3_WIDTH-1:0];
      end
      repeat (10) @(posedge fx3_pclk);
      compare_reset_outputs();
      // FX3 side reset keeps the bridge in reset on its own
      #1 rst = 1'b0;
      fx3_com_rst = 1'b1;
      repeat (2) @(posedge fx3_pclk);
      compare_reset_outputs();
      #1 fx3_com_rst = 1'b0;
      @(posedge fx3_pclk);
      check_value("com_rst", 0, com_rst);
      repeat (50) @(posedge fx3_pclk);
      check_value("pkt_ends", 1, host_i.pkt_ends);
      // Ingress in order and then under back-pressure
      for (int i = 0; i < n_in / 2; i++) host_i.h2d_q.push_back(in_words[i]);
      while (rx_cnt < n_in / 2) @(posedge fx3_pclk);
      #1 bp_mode = 1'b1;
      for (int i = n_in / 2; i < n_in; i++) host_i.h2d_q.push_back(in_words[i]);
      while (rx_cnt < n_in) @(posedge fx3_pclk);
      #1 bp_mode = 1'b0;
      // Egress order and single-word fallback without packet ends while writing
      pkt_before = host_i.pkt_ends;
      eg_go = 1'b1;
      while (eg_rx < n_eg) @(posedge fx3_pclk);
      check_value("pkt_ends", pkt_before, host_i.pkt_ends);
      repeat (64 + 20) @(posedge fx3_pclk);
      check_value("pkt_ends", pkt_before + 1, host_i.pkt_ends);
      check_value("full_writes", 0, host_i.full_writes);
      err_cnt += dut_i.props_i.fail_cnt;
      $display("Words in %0d, words out %0d, errors %0d", rx_cnt, eg_rx, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== tests/fx3_host_model.sv ====
// Behavioral FX3 side for the testbench; holds host queues, drives flags and captures writes
`timescale 1ns/100ps
`include "glip_fx3_macros.svh"

module fx3_host_model import glip_fx3_pkg::*; (
   input  logic       fx3_pclk,
   input  logic       rst,
   input  logic       fx3_slrd_n,
   input  logic       fx3_slwr_n,
   input  logic       fx3_pktend_n,
   input  logic [1:0] fx3_a,
   input  fx3_word_t  fx3_dq_out,
   output fx3_word_t  fx3_dq_in,
   output logic       fx3_flaga_n,
   output logic       fx3_flagb_n,
   output logic       fx3_flagc_n,
   output logic       fx3_flagd_n
);

   localparam int lat = `GLIP_FX3_READ_LATENCY;

   // Host-to-device words waiting and device-to-host words stored
   fx3_word_t h2d_q[$];
   fx3_word_t d2h_q[$];
   fx3_word_t rd_pipe[lat];
   int pkt_ends;
   int full_writes;

   always @(posedge fx3_pclk or posedge rst) begin
      if (rst) begin
         pkt_ends = 0;
         full_writes = 0;
         for (int i = 0; i < lat; i++) begin
            rd_pipe[i] = '0;
         end
         fx3_dq_in <= '0;
         fx3_flaga_n <= 1'b1;
         fx3_flagb_n <= 1'b1;
         fx3_flagc_n <= 1'b0;
         fx3_flagd_n <= 1'b0;
      end else begin
         // Read data shows up lat cycles after the strobe
         for (int i = lat - 1; i > 0; i--) begin
            rd_pipe[i] = rd_pipe[i-1];
         end
         rd_pipe[0] = '0;
         if (!fx3_slrd_n && fx3_a == `GLIP_FX3_EP_OUT && fx3_flagc_n) begin
            rd_pipe[0] = h2d_q.pop_front();
         end
         if (!fx3_slwr_n && fx3_a == `GLIP_FX3_EP_IN) begin
            if (!fx3_flaga_n) begin
               full_writes++;
            end
            d2h_q.push_back(fx3_dq_out);
         end
         if (!fx3_pktend_n && fx3_a == `GLIP_FX3_EP_IN) begin
            pkt_ends++;
         end
         fx3_dq_in <= rd_pipe[lat-1];
         fx3_flaga_n <= !(d2h_q.size() >= 32);
         fx3_flagb_n <= !(d2h_q.size() >= 28);
         fx3_flagc_n <= !(h2d_q.size() == 0);
         fx3_flagd_n <= !(h2d_q.size() <= 4);
      end
   end

endmodule

// ==== tests/glip_fx3_properties.sv ====
// Concurrent checks on the FX3 control pins; attached to the bridge top level by bind
`timescale 1ns/100ps
`include "glip_fx3_macros.svh"

module glip_fx3_properties (
   input logic       fx3_pclk,
   input logic       int_rst,
   input logic       fx3_slrd_n,
   input logic       fx3_slwr_n,
   input logic       fx3_pktend_n,
   input logic [1:0] fx3_a
);

   // Number of failed assertions
   int fail_cnt = 0;

   rd_wr_exclusive: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      !(!fx3_slrd_n && !fx3_slwr_n))
      else begin
         $error("Read and write strobes active in the same cycle");
         fail_cnt++;
      end

   wr_address: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      (!fx3_slwr_n || !fx3_pktend_n) |-> (fx3_a == `GLIP_FX3_EP_IN))
      else begin
         $error("Write or packet end issued with a wrong endpoint address");
         fail_cnt++;
      end

   rd_address: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      !fx3_slrd_n |-> (fx3_a == `GLIP_FX3_EP_OUT))
      else begin
         $error("Read issued with a wrong endpoint address");
         fail_cnt++;
      end

endmodule

// ==== logic/glip_fx3_top.sv ====
// Top level of the FX3 slave-FIFO bridge; connect the FX3 pins and the user valid/ready ports
`timescale 1ns/100ps
`include "glip_fx3_macros.svh"

module glip_fx3_top import glip_fx3_pkg::*; #(
   parameter int buffer_depth = 16,
   parameter int flush_timeout = `GLIP_FX3_FLUSH_TIMEOUT
) (
   input  logic      fx3_pclk,
   input  logic      rst,
   input  logic      fx3_com_rst,
   output logic      com_rst,

   // FX3 interface with the bus split for an external tristate pad
   input  fx3_word_t fx3_dq_in,
   output fx3_word_t fx3_dq_out,
   output logic      fx3_dq_oe,
   output logic      fx3_sloe_n,
   output logic      fx3_slrd_n,
   output logic      fx3_slwr_n,
   output logic      fx3_pktend_n,
   output logic [1:0] fx3_a,
   input  logic      fx3_flaga_n,
   input  logic      fx3_flagb_n,
   input  logic      fx3_flagc_n,
   input  logic      fx3_flagd_n,

   // User side toward the host
   input  logic      fifo_out_valid,
   output logic      fifo_out_ready,
   input  fx3_word_t fifo_out_data,

   // User side from the host
   output logic      fifo_in_valid,
   input  logic      fifo_in_ready,
   output fx3_word_t fifo_in_data
);

   logic int_rst;
   fx3_flags_t flags;
   fx3_ctrl_t ctrl;
   logic eg_full;
   logic eg_empty;
   logic eg_pop;
   logic ig_almost_full;
   logic ig_empty;
   logic ig_push;
   fx3_word_t ig_data;

   assign int_rst = rst | fx3_com_rst;
   assign com_rst = int_rst;

   assign flags.in_full = ~fx3_flaga_n;
   assign flags.in_almost_full = ~fx3_flagb_n;
   assign flags.out_empty = ~fx3_flagc_n;
   assign flags.out_almost_empty = ~fx3_flagd_n;

   assign fx3_slrd_n = ~ctrl.rd;
   assign fx3_slwr_n = ~ctrl.wr;
   assign fx3_sloe_n = ~ctrl.oe;
   assign fx3_pktend_n = ~ctrl.pktend;
   assign fx3_a = ctrl.adr;
   assign fx3_dq_oe = ctrl.dq_drive;

   assign fifo_out_ready = ~eg_full;
   assign fifo_in_valid = ~ig_empty;

   slave_fifo_fsm #(.flush_timeout(flush_timeout)) fsm_i (
      .fx3_pclk, .int_rst, .flags, .ctrl, .eg_empty, .eg_pop,
      .ig_almost_full, .ig_push, .ig_data, .dq_in(fx3_dq_in)
   );

   // Head word goes straight onto the bus
   sync_fifo #(.depth(buffer_depth), .almost_full_margin(1)) egress_fifo_i (
      .fx3_pclk, .int_rst,
      .push(fifo_out_valid), .push_data(fifo_out_data), .full(eg_full), .almost_full(),
      .pop(eg_pop), .pop_data(fx3_dq_out), .empty(eg_empty)
   );

   // Margin absorbs reads still in flight when the machine stops
   sync_fifo #(
      .depth(buffer_depth),
      .almost_full_margin(`GLIP_FX3_READ_LATENCY + 4)
   ) ingress_fifo_i (
      .fx3_pclk, .int_rst,
      .push(ig_push), .push_data(ig_data), .full(), .almost_full(ig_almost_full),
      .pop(fifo_in_ready), .pop_data(fifo_in_data), .empty(ig_empty)
   );

endmodule

// ==== logic/slave_fifo_fsm.sv ====
// FX3 slave-FIFO control machine; drives strobes and address, moves words between bus and FIFOs
`timescale 1ns/100ps
`include "glip_fx3_macros.svh"

module slave_fifo_fsm import glip_fx3_pkg::*; #(
   parameter int flush_timeout = `GLIP_FX3_FLUSH_TIMEOUT
) (
   input  logic       fx3_pclk,
   input  logic       int_rst,
   input  fx3_flags_t flags,
   output fx3_ctrl_t  ctrl,
   input  logic       eg_empty,
   output logic       eg_pop,
   input  logic       ig_almost_full,
   output logic       ig_push,
   output fx3_word_t  ig_data,
   input  fx3_word_t  dq_in
);

   localparam int timer_w = $clog2(flush_timeout + 1);
   localparam int swrw_w = $clog2(`GLIP_FX3_SWRW_WAIT + 1);
   localparam int lat = `GLIP_FX3_READ_LATENCY;

   fx3_state_t state;
   fx3_state_t nxt_state;
   logic [timer_w-1:0] idle_cnt;
   logic [timer_w-1:0] nxt_idle_cnt;
   logic [swrw_w-1:0] swrw_cnt;
   logic [swrw_w-1:0] nxt_swrw_cnt;
   logic flush;
   logic nxt_flush;
   logic [lat-1:0] rd_pipe;
   logic ig_push_q;
   fx3_word_t ig_data_q;

   always_ff @(posedge fx3_pclk or posedge int_rst) begin
      if (int_rst) begin
         state <= st_idle;
         idle_cnt <= '0;
         swrw_cnt <= '0;
         // Send a zero-length packet once after reset
         flush <= 1'b1;
      end else begin
         state <= nxt_state;
         idle_cnt <= nxt_idle_cnt;
         swrw_cnt <= nxt_swrw_cnt;
         flush <= nxt_flush;
      end
   end

   always_comb begin
      nxt_state = state;
      nxt_idle_cnt = (idle_cnt != '0) ? idle_cnt - 1'b1 : '0;
      nxt_swrw_cnt = (swrw_cnt != '0) ? swrw_cnt - 1'b1 : '0;
      nxt_flush = flush | (idle_cnt == timer_w'(1));
      ctrl = '0;
      ctrl.adr = `GLIP_FX3_EP_IN;

      case (state)
         st_idle: begin
            if (!flags.in_full && !eg_empty) begin
               nxt_state = st_flg_a_rcvd;
            end else if (flush) begin
               nxt_state = st_write_flush;
            end else if (!flags.out_empty && !ig_almost_full) begin
               nxt_state = st_flg_c_rcvd;
            end
         end

         // Write path toward the host
         st_flg_a_rcvd: begin
            ctrl.dq_drive = 1'b1;
            nxt_idle_cnt = '0;
            nxt_flush = 1'b0;
            nxt_swrw_cnt = swrw_w'(`GLIP_FX3_SWRW_WAIT);
            nxt_state = st_wait_flg_b;
         end
         st_wait_flg_b: begin
            ctrl.dq_drive = 1'b1;
            if (flags.in_full) begin
               nxt_idle_cnt = timer_w'(flush_timeout);
               nxt_state = st_idle;
            end else if (!flags.in_almost_full) begin
               nxt_state = st_write;
            end else if (swrw_cnt == swrw_w'(1)) begin
               nxt_state = st_sw_write;
            end
         end
         st_write: begin
            ctrl.dq_drive = 1'b1;
            if (eg_empty) begin
               nxt_idle_cnt = timer_w'(flush_timeout);
               nxt_state = st_idle;
            end else begin
               ctrl.wr = 1'b1;
               if (flags.in_almost_full) begin
                  nxt_state = st_write_drain_1;
               end
            end
         end
         // FX3 still takes two words after almost full
         st_write_drain_1: begin
            ctrl.dq_drive = 1'b1;
            ctrl.wr = ~eg_empty;
            nxt_state = st_write_drain_2;
         end
         st_write_drain_2: begin
            ctrl.dq_drive = 1'b1;
            ctrl.wr = ~eg_empty;
            nxt_idle_cnt = timer_w'(flush_timeout);
            nxt_state = st_idle;
         end
         st_sw_write: begin
            ctrl.dq_drive = 1'b1;
            ctrl.wr = ~eg_empty;
            nxt_swrw_cnt = swrw_w'(3);
            nxt_state = st_sw_write_waitflg;
         end
         // Let the flags settle after the single word
         st_sw_write_waitflg: begin
            ctrl.dq_drive = 1'b1;
            if (swrw_cnt == swrw_w'(1)) begin
               nxt_idle_cnt = timer_w'(flush_timeout);
               nxt_state = st_idle;
            end
         end
         st_write_flush: begin
            ctrl.dq_drive = 1'b1;
            ctrl.pktend = ~flags.in_full;
            nxt_flush = 1'b0;
            nxt_state = st_idle;
         end

         // Read path from the host
         st_flg_c_rcvd: begin
            ctrl.adr = `GLIP_FX3_EP_OUT;
            nxt_swrw_cnt = swrw_w'(`GLIP_FX3_SWRW_WAIT);
            nxt_state = st_wait_flg_d;
         end
         st_wait_flg_d: begin
            ctrl.adr = `GLIP_FX3_EP_OUT;
            if (flags.out_empty) begin
               nxt_state = st_idle;
            end else if (!flags.out_almost_empty) begin
               nxt_state = st_read;
            end else if (swrw_cnt == swrw_w'(1)) begin
               nxt_state = st_sw_read;
            end
         end
         st_read: begin
            ctrl.adr = `GLIP_FX3_EP_OUT;
            ctrl.oe = 1'b1;
            ctrl.rd = ~ig_almost_full;
            if (ig_almost_full) begin
               nxt_state = st_read_drain_4;
            end else if (flags.out_almost_empty) begin
               nxt_state = st_read_drain_1;
            end
         end
         st_sw_read: begin
            ctrl.adr = `GLIP_FX3_EP_OUT;
            ctrl.oe = 1'b1;
            ctrl.rd = 1'b1;
            nxt_state = st_read_drain_4;
         end
         st_read_drain_1, st_read_drain_2, st_read_drain_3: begin
            ctrl.adr = `GLIP_FX3_EP_OUT;
            ctrl.oe = 1'b1;
            ctrl.rd = 1'b1;
            nxt_state = (state == st_read_drain_3) ? st_read_drain_4 :
                        (state == st_read_drain_2) ? st_read_drain_3 : st_read_drain_2;
         end
         // Hold oe until the last issued read has returned
         st_read_drain_4, st_read_drain_5, st_read_drain_6: begin
            ctrl.adr = `GLIP_FX3_EP_OUT;
            ctrl.oe = 1'b1;
            if (state == st_read_drain_4) begin
               nxt_state = st_read_drain_5;
            end else if (state == st_read_drain_5 && lat > 2) begin
               nxt_state = st_read_drain_6;
            end else begin
               nxt_state = st_idle;
            end
         end
         default: nxt_state = st_idle;
      endcase
   end

   assign eg_pop = ctrl.wr;

   // Qualified read strobes travel until their word is on the bus
   always_ff @(posedge fx3_pclk or posedge int_rst) begin
      if (int_rst) begin
         rd_pipe <= '0;
         ig_push_q <= 1'b0;
      end else begin
         rd_pipe[0] <= ctrl.rd & ~flags.out_empty;
         for (int i = 1; i < lat; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
         end
         ig_push_q <= rd_pipe[lat-1];
      end
   end

   always_ff @(posedge fx3_pclk) begin
      ig_data_q <= dq_in;
   end

   assign ig_push = ig_push_q;
   assign ig_data = ig_data_q;

endmodule

// ==== logic/sync_fifo.sv ====
// First-word-fall-through FIFO on fx3_pclk; buffers data in both directions of the bridge
`timescale 1ns/100ps

module sync_fifo import glip_fx3_pkg::*; #(
   parameter int depth = 16,
   parameter int almost_full_margin = 6
) (
   input  logic      fx3_pclk,
   input  logic      int_rst,
   input  logic      push,
   input  fx3_word_t push_data,
   output logic      full,
   output logic      almost_full,
   input  logic      pop,
   output fx3_word_t pop_data,
   output logic      empty
);

   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);

   fx3_word_t mem [depth];
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [cw-1:0] count;
   logic do_push;
   logic do_pop;

   assign full = (count == cw'(depth));
   assign empty = (count == '0);
   // Free space at or below the margin
   assign almost_full = (cw'(depth) - count) <= cw'(almost_full_margin);

   assign do_push = push & ~full;
   assign do_pop = pop & ~empty;

   // Head word shown without a read request
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge fx3_pclk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge fx3_pclk or posedge int_rst) begin
      if (int_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== logic/glip_fx3_pkg.sv ====
// Types shared by the FX3 bridge RTL and its testbench; import with glip_fx3_pkg::*
`include "glip_fx3_macros.svh"

package glip_fx3_pkg;

   typedef logic [`GLIP_FX3_WIDTH-1:0] fx3_word_t;

   // Flag pins after inversion with every bit active high
   typedef struct packed {
      logic in_full;
      logic in_almost_full;
      logic out_empty;
      logic out_almost_empty;
   } fx3_flags_t;

   // Control outputs before inversion onto the pins
   typedef struct packed {
      logic       rd;
      logic       wr;
      logic       oe;
      logic       pktend;
      logic       dq_drive;
      logic [1:0] adr;
   } fx3_ctrl_t;

   typedef enum logic [4:0] {
      st_idle, st_flg_c_rcvd, st_wait_flg_d, st_read,
      st_read_drain_1, st_read_drain_2, st_read_drain_3,
      st_read_drain_4, st_read_drain_5, st_read_drain_6,
      st_flg_a_rcvd, st_wait_flg_b, st_write, st_write_drain_1, st_write_drain_2,
      st_write_flush, st_sw_read, st_sw_write, st_sw_write_waitflg
   } fx3_state_t;

endpackage

// ==== logic/glip_fx3_macros.svh ====
// Shared widths, FX3 endpoint addresses and timing constants; include wherever they are needed
`ifndef GLIP_FX3_MACROS_SVH
`define GLIP_FX3_MACROS_SVH

// Data bus width of the FX3 GPIF interface
`define GLIP_FX3_WIDTH 16

// Endpoint addresses on fx3_a
`define GLIP_FX3_EP_IN 2'd0
`define GLIP_FX3_EP_OUT 2'd3

// Cycles from a read strobe to data on the bus (3 suits fast clocks)
`define GLIP_FX3_READ_LATENCY 2

// Wait for an almost flag before falling back to a single-word transfer
`define GLIP_FX3_SWRW_WAIT 15

// Idle cycles before a zero-length packet is sent
`define GLIP_FX3_FLUSH_TIMEOUT 10000

`endif
